// ==== rw_pkg.sv ====
package rw_pkg;

   localparam int N_THREADS     = 8;
   localparam int LOG_CQ_SLOTS  = 6;
   localparam int LOG_RW_WIDTH  = 2;    // objects are 4 bytes wide.
   localparam int REQ_LOG_DEPTH = 3;

   typedef logic [$clog2(N_THREADS)-1:0] thread_id_t;
   typedef logic [LOG_CQ_SLOTS-1:0]      cq_slot_t;
   typedef logic [(8 << LOG_RW_WIDTH)-1:0] object_t;
   typedef logic [511:0]                 line_t;
   typedef logic [7:0]                   fifo_size_t;

   typedef enum logic [3:0] {
      TASK_NORMAL           = 4'd0,
      TASK_UNDO_LOG_RESTORE = 4'd1,
      TASK_OTHER            = 4'd2
   } task_type_e;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
      task_type_e  ttype;
      logic        no_read;
   } task_t;

   typedef struct packed {
      task_t      task_desc;
      cq_slot_t   cq_slot;
      thread_id_t thread;
      object_t    object;
   } rw_write_t;

   // one class per cycle, counted by the control block.
   typedef enum logic [2:0] {
      CYC_IDLE        = 3'd0,
      CYC_NO_TASK     = 3'd1,
      CYC_ACCEPT      = 3'd2,
      CYC_STALL_FULL  = 3'd3,
      CYC_STALL_MEM   = 3'd4,
      CYC_STALL_OTHER = 3'd5
   } cycle_class_e;

   localparam logic [7:0] REG_RW_BASE     = 8'h10;
   localparam logic [7:0] REG_OUT_THRESH  = 8'h14;
   localparam logic [7:0] REG_N_DEQUEUES  = 8'h18;
   localparam logic [7:0] REG_START       = 8'h1C;
   localparam logic [7:0] REG_CNT_NO_TASK = 8'h80;
   localparam logic [7:0] REG_CNT_ACCEPT  = 8'h84;
   localparam logic [7:0] REG_CNT_FULL    = 8'h88;
   localparam logic [7:0] REG_CNT_MEM     = 8'h8C;
   localparam logic [7:0] REG_CNT_OTHER   = 8'hA0;
   localparam logic [7:0] REG_STATUS      = 8'hA4;

endpackage

// ==== rw_ifs.sv ====
`timescale 1ns/1ps

interface rw_issue_if;
   import rw_pkg::*;

   logic       accept;       // one-cycle strobe per accepted task.
   logic       needs_read;
   logic       is_restore;
   task_t      task_desc;
   cq_slot_t   cq_slot;
   thread_id_t thread;
   logic       req_ready;    // request queue has room.
   logic       held_free;    // held register empty or draining now.

   modport decode (
      output accept, needs_read, is_restore, task_desc, cq_slot, thread,
      input  req_ready, held_free
   );

   modport execute (
      input  accept, needs_read, task_desc, thread,
      output req_ready
   );

   modport result (
      input  accept, needs_read, is_restore, task_desc, cq_slot, thread,
      output held_free
   );
endinterface

interface rw_ctrl_if;
   import rw_pkg::*;

   logic [31:0]  base_addr;
   fifo_size_t   out_thresh;
   logic         dequeue_open;
   logic         started;
   cycle_class_e cycle_class;    // registered, one cycle behind the task port.

   modport decode (input out_thresh, dequeue_open, started, output cycle_class);
   modport execute (input base_addr);
   modport ctrl (output base_addr, out_thresh, dequeue_open, started, input cycle_class);
endinterface

// ==== fifo.sv ====
`timescale 1ns/1ps

module fifo #(
   parameter int WIDTH     = 8,
   parameter int LOG_DEPTH = 3
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             empty
);
   logic [WIDTH-1:0]   mem [2**LOG_DEPTH];
   logic [LOG_DEPTH:0] wr_ptr;    // extra bit tells full from empty.
   logic [LOG_DEPTH:0] rd_ptr;
   logic               push;
   logic               pop;

   assign empty = wr_ptr == rd_ptr;
   assign full  = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]) &&
                  (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);
   assign push  = wr_en && !full;
   assign pop   = rd_en && !empty;

   // head word is visible without a read strobe.
   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== rw_task_decode.sv ====
`timescale 1ns/1ps

module rw_task_decode (
   input  logic               clk,
   input  logic               rstn,
   input  logic               task_in_valid,
   output logic               task_in_ready,
   input  rw_pkg::task_t      task_in,
   input  rw_pkg::cq_slot_t   cq_slot_in,
   input  rw_pkg::thread_id_t thread_id_in,
   input  logic               gvt_slot_valid,
   input  rw_pkg::cq_slot_t   gvt_slot,
   input  rw_pkg::fifo_size_t task_out_fifo_occ,
   rw_issue_if.decode         issue,
   rw_ctrl_if.decode          ctrl
);
   import rw_pkg::*;

   logic         below_thresh;
   logic         gvt_hit;
   logic         can_dequeue;
   logic         resource_ok;
   cycle_class_e cycle_class_d;

   assign issue.is_restore = task_in.ttype == TASK_UNDO_LOG_RESTORE;
   assign issue.needs_read = !task_in.no_read && !issue.is_restore;
   assign issue.task_desc  = task_in;
   assign issue.cq_slot    = cq_slot_in;
   assign issue.thread     = thread_id_in;

   assign below_thresh = task_out_fifo_occ < ctrl.out_thresh;
   assign gvt_hit      = gvt_slot_valid && (gvt_slot == cq_slot_in);    // oldest task always goes.
   assign can_dequeue  = ctrl.started && ctrl.dequeue_open && (below_thresh || gvt_hit);
   assign resource_ok  = issue.needs_read ? issue.req_ready : issue.held_free;

   assign task_in_ready = can_dequeue && resource_ok;
   assign issue.accept  = task_in_valid && task_in_ready;

   always_comb begin
      if (!ctrl.started) begin
         cycle_class_d = CYC_IDLE;
      end else if (!task_in_valid) begin
         cycle_class_d = CYC_NO_TASK;
      end else if (task_in_ready) begin
         cycle_class_d = CYC_ACCEPT;
      end else if (!(below_thresh || gvt_hit)) begin
         cycle_class_d = CYC_STALL_FULL;
      end else if (issue.needs_read && !issue.req_ready) begin
         cycle_class_d = CYC_STALL_MEM;
      end else begin
         cycle_class_d = CYC_STALL_OTHER;    // budget spent or held register busy.
      end
   end

   // the control block sees each class one cycle later.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         ctrl.cycle_class <= CYC_IDLE;
      end else begin
         ctrl.cycle_class <= cycle_class_d;
      end
   end

endmodule

// ==== rw_read_request.sv ====
`timescale 1ns/1ps

module rw_read_request (
   input  logic               clk,
   input  logic               rstn,
   output logic               arvalid,
   input  logic               arready,
   output logic [31:0]        araddr,
   output rw_pkg::thread_id_t arid,
   rw_issue_if.execute        issue,
   rw_ctrl_if.execute         ctrl
);
   import rw_pkg::*;

   logic [31:0] req_addr;
   logic        req_push;
   logic        req_full;
   logic        req_empty;

   assign req_addr = ctrl.base_addr + (issue.task_desc.locale << LOG_RW_WIDTH);
   assign req_push = issue.accept && issue.needs_read;

   assign issue.req_ready = !req_full;
   assign arvalid         = !req_empty;

   // requests leave in acceptance order, the thread id doubles as the read id.
   fifo #(
      .WIDTH     (32 + $bits(thread_id_t)),
      .LOG_DEPTH (REQ_LOG_DEPTH)
   ) req_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (req_push),
      .wr_data ({req_addr, issue.thread}),
      .rd_en   (arvalid && arready),
      .rd_data ({araddr, arid}),
      .full    (req_full),
      .empty   (req_empty)
   );

endmodule

// ==== rw_result_select.sv ====
`timescale 1ns/1ps

module rw_result_select (
   input  logic               clk,
   input  logic               rstn,
   input  logic               rvalid,
   output logic               rready,
   input  rw_pkg::thread_id_t rid,
   input  rw_pkg::line_t      rdata,
   output logic               task_out_valid,
   input  logic               task_out_ready,
   output rw_pkg::rw_write_t  task_out,
   rw_issue_if.result         issue
);
   import rw_pkg::*;

   task_t      desc_mem [N_THREADS];
   cq_slot_t   slot_mem [N_THREADS];
   object_t    undo_log [2**LOG_CQ_SLOTS];

   logic       held_valid;
   logic       held_restore;
   task_t      held_task;
   cq_slot_t   held_slot;
   thread_id_t held_thread;
   object_t    undo_word;
   logic       load_held;
   logic       out_fire;
   task_t      resp_task;

   assign load_held = issue.accept && !issue.needs_read;
   assign out_fire  = task_out_valid && task_out_ready;

   // the held entry always wins the output, so it drains whenever ready is high.
   assign issue.held_free = !held_valid || task_out_ready;

   always_ff @(posedge clk) begin
      if (issue.accept) begin
         desc_mem[issue.thread] <= issue.task_desc;
         slot_mem[issue.thread] <= issue.cq_slot;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held_valid <= 1'b0;
      end else if (load_held) begin
         held_valid <= 1'b1;
      end else if (held_valid && task_out_ready) begin
         held_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load_held) begin
         held_task    <= issue.task_desc;
         held_slot    <= issue.cq_slot;
         held_thread  <= issue.thread;
         held_restore <= issue.is_restore;
      end
   end

   // read before write, a restore sees the log as it was before this edge.
   always_ff @(posedge clk) begin
      if (out_fire) begin
         undo_log[task_out.cq_slot] <= task_out.object;
      end
      if (issue.accept && issue.is_restore) begin
         undo_word <= undo_log[issue.cq_slot];
      end
   end

   assign resp_task = desc_mem[rid];

   always_comb begin
      if (held_valid) begin
         task_out.task_desc = held_task;
         task_out.cq_slot   = held_slot;
         task_out.thread    = held_thread;
         task_out.object    = held_restore ? undo_word : '0;    // no-read tasks carry zero.
         task_out_valid     = 1'b1;
         rready             = 1'b0;
      end else begin
         task_out.task_desc = resp_task;
         task_out.cq_slot   = slot_mem[rid];
         task_out.thread    = rid;
         task_out.object    = rdata[$bits(object_t) * resp_task.locale[3:0] +: $bits(object_t)];
         task_out_valid     = rvalid;
         rready             = rvalid && task_out_ready;
      end
   end

endmodule

// ==== rw_ctrl_regs.sv ====
`timescale 1ns/1ps

module rw_ctrl_regs (
   input  logic               clk,
   input  logic               rstn,
   input  logic               reg_wvalid,
   input  logic [7:0]         reg_waddr,
   input  logic [31:0]        reg_wdata,
   input  logic               reg_arvalid,
   input  logic [7:0]         reg_araddr,
   output logic               reg_rvalid,
   output logic [31:0]        reg_rdata,
   input  rw_pkg::fifo_size_t task_out_fifo_occ,
   input  logic [7:0]         status_bits,
   rw_ctrl_if.ctrl            ctrl
);
   import rw_pkg::*;

   logic [31:0] dequeues_left;
   logic        budget_write;
   logic        budget_write_q;
   logic        accept_pending;
   logic [31:0] cnt_no_task;
   logic [31:0] cnt_accept;
   logic [31:0] cnt_full;
   logic [31:0] cnt_mem;
   logic [31:0] cnt_other;

   assign budget_write = reg_wvalid && (reg_waddr == REG_N_DEQUEUES);

   // an accept from the cycle before a budget write is not charged to the new budget.
   assign accept_pending = (ctrl.cycle_class == CYC_ACCEPT) && !budget_write_q;

   // the class arrives a cycle late, so the last accept is taken off here.
   assign ctrl.dequeue_open = dequeues_left > {31'b0, accept_pending};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ctrl.base_addr  <= '0;
         ctrl.out_thresh <= '1;
         ctrl.started    <= 1'b0;
         dequeues_left   <= '1;
         budget_write_q  <= 1'b0;
      end else begin
         budget_write_q <= budget_write;
         if (reg_wvalid) begin
            case (reg_waddr)
               REG_RW_BASE:    ctrl.base_addr  <= {reg_wdata[29:0], 2'b00};
               REG_OUT_THRESH: ctrl.out_thresh <= reg_wdata[7:0];
               REG_START:      ctrl.started    <= reg_wdata[0];
               default: ;
            endcase
         end
         if (budget_write) begin
            dequeues_left <= reg_wdata;
         end else if (accept_pending) begin
            dequeues_left <= dequeues_left - 32'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cnt_no_task <= '0;
         cnt_accept  <= '0;
         cnt_full    <= '0;
         cnt_mem     <= '0;
         cnt_other   <= '0;
      end else begin
         case (ctrl.cycle_class)
            CYC_NO_TASK:     cnt_no_task <= cnt_no_task + 32'd1;
            CYC_ACCEPT:      cnt_accept  <= cnt_accept + 32'd1;
            CYC_STALL_FULL:  cnt_full    <= cnt_full + 32'd1;
            CYC_STALL_MEM:   cnt_mem     <= cnt_mem + 32'd1;
            CYC_STALL_OTHER: cnt_other   <= cnt_other + 32'd1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            REG_RW_BASE:     reg_rdata <= ctrl.base_addr;
            REG_OUT_THRESH:  reg_rdata <= {24'b0, task_out_fifo_occ};    // live occupancy.
            REG_N_DEQUEUES:  reg_rdata <= dequeues_left;
            REG_START:       reg_rdata <= {31'b0, ctrl.started};
            REG_CNT_NO_TASK: reg_rdata <= cnt_no_task;
            REG_CNT_ACCEPT:  reg_rdata <= cnt_accept;
            REG_CNT_FULL:    reg_rdata <= cnt_full;
            REG_CNT_MEM:     reg_rdata <= cnt_mem;
            REG_CNT_OTHER:   reg_rdata <= cnt_other;
            REG_STATUS:      reg_rdata <= {24'b0, status_bits};
            default:         reg_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== rw_read_top.sv ====
`timescale 1ns/1ps

module rw_read_top (
   input  logic               clk,
   input  logic               rstn,
   input  logic               task_in_valid,
   output logic               task_in_ready,
   input  rw_pkg::task_t      task_in,
   input  rw_pkg::cq_slot_t   cq_slot_in,
   input  rw_pkg::thread_id_t thread_id_in,
   input  logic               gvt_slot_valid,
   input  rw_pkg::cq_slot_t   gvt_slot,
   output logic               arvalid,
   input  logic               arready,
   output logic [31:0]        araddr,
   output rw_pkg::thread_id_t arid,
   input  logic               rvalid,
   output logic               rready,
   input  rw_pkg::thread_id_t rid,
   input  rw_pkg::line_t      rdata,
   output logic               task_out_valid,
   input  logic               task_out_ready,
   output rw_pkg::rw_write_t  task_out,
   input  rw_pkg::fifo_size_t task_out_fifo_occ,
   input  logic               reg_wvalid,
   input  logic [7:0]         reg_waddr,
   input  logic [31:0]        reg_wdata,
   input  logic               reg_arvalid,
   input  logic [7:0]         reg_araddr,
   output logic               reg_rvalid,
   output logic [31:0]        reg_rdata
);
   logic [7:0] status_bits;

   rw_issue_if issue ();
   rw_ctrl_if  ctrl ();

   assign status_bits = {arvalid, arready, rvalid, rready,
                         task_in_valid, task_in_ready, task_out_valid, task_out_ready};

   rw_task_decode u_decode (
      .clk (clk), .rstn (rstn),
      .task_in_valid (task_in_valid), .task_in_ready (task_in_ready),
      .task_in (task_in), .cq_slot_in (cq_slot_in), .thread_id_in (thread_id_in),
      .gvt_slot_valid (gvt_slot_valid), .gvt_slot (gvt_slot),
      .task_out_fifo_occ (task_out_fifo_occ),
      .issue (issue.decode), .ctrl (ctrl.decode)
   );

   rw_read_request u_execute (
      .clk (clk), .rstn (rstn),
      .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
      .issue (issue.execute), .ctrl (ctrl.execute)
   );

   rw_result_select u_result (
      .clk (clk), .rstn (rstn),
      .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
      .task_out_valid (task_out_valid), .task_out_ready (task_out_ready),
      .task_out (task_out), .issue (issue.result)
   );

   rw_ctrl_regs u_ctrl (
      .clk (clk), .rstn (rstn),
      .reg_wvalid (reg_wvalid), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
      .reg_arvalid (reg_arvalid), .reg_araddr (reg_araddr),
      .reg_rvalid (reg_rvalid), .reg_rdata (reg_rdata),
      .task_out_fifo_occ (task_out_fifo_occ), .status_bits (status_bits),
      .ctrl (ctrl.ctrl)
   );

endmodule

// ==== tb_rw_read.sv ====
`timescale 1ns/1ps

module tb_rw_read;
   import rw_pkg::*;

   localparam int N_RANDOM = 80;
   localparam int BUDGET   = 6;
   localparam int N_TASKS  = N_RANDOM + BUDGET + 3;
   localparam int THRESH   = 6;

   logic        clk;
   logic        rstn;
   logic        task_in_valid, task_in_ready, gvt_slot_valid, arvalid, arready;
   logic        rvalid, rready, task_out_valid, task_out_ready;
   logic        reg_wvalid, reg_arvalid, reg_rvalid;
   task_t       task_in;
   cq_slot_t    cq_slot_in, gvt_slot;
   thread_id_t  thread_id_in, arid, rid;
   logic [31:0] araddr, reg_wdata, reg_rdata;
   logic [7:0]  reg_waddr, reg_araddr;
   line_t       rdata;
   rw_write_t   task_out;
   fifo_size_t  task_out_fifo_occ;

   integer      seed;
   int          n_errors, n_acc, n_out, n_issued, issue_limit, cyc, started_cycles;
   logic        started_m, last_accept;
   logic [31:0] base_m;
   fifo_size_t  thresh_m;
   rw_write_t   exp_out [N_THREADS];
   logic        pend [N_THREADS];
   object_t     model_log [2**LOG_CQ_SLOTS];
   cq_slot_t    written_q [$];
   logic [31:0] exp_addr_q [$];
   thread_id_t  exp_id_q [$];
   logic [31:0] mem_addr_q [$];
   thread_id_t  mem_id_q [$];
   int          mem_due_q [$];

   rw_read_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // word i of a line holds its own byte address plus i.
   function automatic line_t make_line(input logic [31:0] addr);
      line_t words;
      for (int i = 0; i < 16; i++) begin
         words[32*i +: 32] = (addr & 32'hFFFF_FFC0) + 32'(4 * i) + 32'(i);
      end
      return words;
   endfunction

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected) begin
         n_errors++;
         $display("ERR %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      reg_wvalid <= 1'b1;
      reg_waddr  <= addr;
      reg_wdata  <= data;
      @(posedge clk);
      reg_wvalid <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      int waited;
      @(posedge clk);
      reg_arvalid <= 1'b1;
      reg_araddr  <= addr;
      @(posedge clk);
      reg_arvalid <= 1'b0;
      waited = 0;
      while (!reg_rvalid && waited < 10) begin
         @(posedge clk);
         waited++;
      end
      data = reg_rdata;
      if (!reg_rvalid) begin
         n_errors++;
         $display("register read at %h got no response", addr);
      end
   endtask

   // works on the values that stood just before this clock edge.
   task automatic observe_cycle();
      rw_write_t   want;
      logic [31:0] addr;
      logic        blocked;
      cyc++;
      if (started_m) begin
         started_cycles++;
      end
      last_accept = task_in_valid && task_in_ready;
      blocked = (task_out_fifo_occ >= thresh_m) && !(gvt_slot_valid && gvt_slot == cq_slot_in);
      check_value("task_in_ready", last_accept && blocked, 1'b0);
      check_value("rready", rready && !task_out_ready, 1'b0);
      if (last_accept) begin
         want.task_desc = task_in;
         want.cq_slot   = cq_slot_in;
         want.thread    = thread_id_in;
         want.object    = '0;
         addr = base_m + (task_in.locale << 2);
         if (task_in.ttype == TASK_UNDO_LOG_RESTORE) begin
            want.object = model_log[cq_slot_in];    // log as it was before this edge.
         end else if (!task_in.no_read) begin
            want.object = (addr & 32'hFFFF_FFC0) + 5 * task_in.locale[3:0];
            exp_addr_q.push_back(addr);
            exp_id_q.push_back(thread_id_in);
         end
         exp_out[thread_id_in] = want;
         pend[thread_id_in]    = 1'b1;
         n_acc++;
      end
      if (task_out_valid && task_out_ready) begin
         if (!pend[task_out.thread]) begin
            n_errors++;
            $display("output for thread %0d arrived with no task outstanding", task_out.thread);
         end else begin
            want = exp_out[task_out.thread];
            check_value("task_out.task_desc", task_out.task_desc, want.task_desc);
            check_value("task_out.cq_slot", task_out.cq_slot, want.cq_slot);
            check_value("task_out.object", task_out.object, want.object);
            model_log[want.cq_slot] = want.object;
            written_q.push_back(want.cq_slot);
            pend[task_out.thread] = 1'b0;
            n_out++;
         end
      end
      if (arvalid && arready) begin
         if (exp_addr_q.size() == 0) begin
            n_errors++;
            $display("read request issued with no read task outstanding");
         end else begin
            check_value("araddr", araddr, exp_addr_q.pop_front());
            check_value("arid", arid, exp_id_q.pop_front());
         end
         mem_addr_q.push_back(araddr);
         mem_id_q.push_back(arid);
         mem_due_q.push_back(cyc + 1 + rand_below(6));
      end
      if (rvalid && rready) begin
         void'(mem_addr_q.pop_front());
         void'(mem_id_q.pop_front());
         void'(mem_due_q.pop_front());
      end
      if (reg_wvalid) begin
         case (reg_waddr)
            REG_START:      started_m = reg_wdata[0];
            REG_RW_BASE:    base_m    = {reg_wdata[29:0], 2'b00};
            REG_OUT_THRESH: thresh_m  = reg_wdata[7:0];
            default: ;
         endcase
      end
   endtask

   task automatic drive_cycle();
      task_t      nxt;
      thread_id_t thr;
      cq_slot_t   slot;
      int         kind;
      int         start;
      logic       found;
      slot  = cq_slot_in;
      found = 1'b0;
      start = rand_below(N_THREADS);
      task_out_ready    <= rand_below(10) < 7;
      arready           <= rand_below(4) != 0;
      task_out_fifo_occ <= fifo_size_t'(rand_below(THRESH + 4));
      if (last_accept || !task_in_valid) begin
         for (int i = 0; i < N_THREADS; i++) begin
            if (!found && n_issued < issue_limit && !pend[(start + i) % N_THREADS]) begin
               found = 1'b1;
               thr   = thread_id_t'((start + i) % N_THREADS);
            end
         end
         if (found) begin
            kind        = rand_below(8);
            nxt.ts      = $random(seed);
            nxt.locale  = $random(seed);
            nxt.ttype   = rand_below(2) ? TASK_NORMAL : TASK_OTHER;
            nxt.no_read = (kind == 5) || (kind == 6);
            slot        = cq_slot_t'(rand_below(64));
            if (kind == 7 && written_q.size() > 0) begin
               nxt.ttype = TASK_UNDO_LOG_RESTORE;    // only slots that an output wrote.
               slot      = written_q[rand_below(written_q.size())];
            end
            task_in      <= nxt;
            cq_slot_in   <= slot;
            thread_id_in <= thr;
            n_issued++;
         end
         task_in_valid <= found;
      end
      gvt_slot_valid <= rand_below(2);
      gvt_slot       <= rand_below(2) ? slot : cq_slot_t'(rand_below(64));
      // memory answers in order once the head request is due.
      if (!rvalid || rready) begin
         rvalid <= 1'b0;
         if (mem_addr_q.size() > 0 && cyc >= mem_due_q[0]) begin
            rvalid <= 1'b1;
            rid    <= mem_id_q[0];
            rdata  <= make_line(mem_addr_q[0]);
         end
      end
   endtask

   always @(posedge clk) begin
      if (rstn) begin
         observe_cycle();
         drive_cycle();
      end
   end

   initial begin
      logic [31:0] cnt [5];
      logic [31:0] cnt_sum;
      seed              = 70;
      n_errors          = 0;
      n_acc             = 0;
      n_out             = 0;
      n_issued          = 0;
      issue_limit       = 0;
      cyc               = 0;
      started_cycles    = 0;
      started_m         = 1'b0;
      last_accept       = 1'b0;
      base_m            = '0;
      thresh_m          = '1;
      for (int i = 0; i < N_THREADS; i++) begin
         pend[i] = 1'b0;
      end
      rstn              = 1'b0;
      task_in_valid     = 1'b0;
      task_in           = '0;
      cq_slot_in        = '0;
      thread_id_in      = '0;
      gvt_slot_valid    = 1'b0;
      gvt_slot          = '0;
      arready           = 1'b0;
      rvalid            = 1'b0;
      rid               = '0;
      rdata             = '0;
      task_out_ready    = 1'b0;
      task_out_fifo_occ = '0;
      reg_wvalid        = 1'b0;
      reg_waddr         = '0;
      reg_wdata         = '0;
      reg_arvalid       = 1'b0;
      reg_araddr        = '0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      write_reg(REG_RW_BASE, 32'h0000_4000);
      write_reg(REG_OUT_THRESH, THRESH);
      write_reg(REG_START, 32'd1);
      issue_limit <= N_RANDOM;
      wait (n_out == N_RANDOM);
      write_reg(REG_N_DEQUEUES, BUDGET);
      issue_limit <= N_TASKS;
      wait (n_acc == N_RANDOM + BUDGET);
      repeat (30) @(posedge clk);
      check_value("n_accepted", n_acc, N_RANDOM + BUDGET);
      write_reg(REG_N_DEQUEUES, 32'hFFFF_FFFF);
      wait (n_out == N_TASKS);
      write_reg(REG_START, 32'd0);
      repeat (3) @(posedge clk);
      read_reg(REG_CNT_NO_TASK, cnt[0]);
      read_reg(REG_CNT_ACCEPT, cnt[1]);
      read_reg(REG_CNT_FULL, cnt[2]);
      read_reg(REG_CNT_MEM, cnt[3]);
      read_reg(REG_CNT_OTHER, cnt[4]);
      cnt_sum = cnt[0] + cnt[1] + cnt[2] + cnt[3] + cnt[4];
      check_value("cnt_sum", cnt_sum, started_cycles);
      check_value("cnt_accept", cnt[1], n_acc);
      check_value("task_out_valid", task_out_valid, 1'b0);
      check_value("reads_outstanding", exp_addr_q.size() + mem_addr_q.size(), 0);
      $display("run complete: %0d accepted, %0d outputs, %0d errors", n_acc, n_out, n_errors);
      if (n_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      repeat (N_TASKS * 200 + 1000) @(posedge clk);
      $display("timeout: the tasks did not complete within the cycle limit");
      $display("test failed");
      $finish;
   end

endmodule

// ==== rw_read_top.f ====
rw_pkg.sv
rw_ifs.sv
fifo.sv
rw_task_decode.sv
rw_read_request.sv
rw_result_select.sv
rw_ctrl_regs.sv
rw_read_top.sv
tb_rw_read.sv
